// ==== all.f ====
cromPkg.sv
consPkg.sv
consStatusIf.sv
clkEnable.sv
cromTable.sv
microSeq.sv
consIntf.sv
consCore.sv
tbConsCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the console control testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tbConsCore -f all.f -o simv \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log

grep -q "Something failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// ==== tbConsCore.sv ====
// Testbench for the console control top level with a reference model, checker and watchdog
`timescale 1ns/1ps

module tbConsCore
   import cromPkg::*;
   import consPkg::*;
();

   ////////////////////////////////////////
   // Test setup
   ////////////////////////////////////////

   // Console commands
   localparam logic [2:0] CMD_RESET = 3'd0;
   localparam logic [2:0] CMD_EXEC  = 3'd1;
   localparam logic [2:0] CMD_CONT  = 3'd2;
   localparam logic [2:0] CMD_RUN   = 3'd3;
   localparam logic [2:0] CMD_HALT  = 3'd4;

   // Five directed tests then the random run
   localparam int NUM_RANDOM      = 12;
   localparam int NUM_TESTS       = 5 + NUM_RANDOM;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

   // What one command did to the machine
   typedef struct packed {
      logic [15:0]       testNum;
      logic [2:0]        cmd;
      consStatus_t       flags;
      consStatus_t       flagsAfter;
      consStatus_t       seen;
      logic [STEP_W-1:0] settleDelta;
      logic [STEP_W-1:0] pauseDelta;
   } obs_t;

   // What it should have done
   typedef struct packed {
      consStatus_t       flags;
      consStatus_t       rise;
      logic              checkSettle;
      logic [STEP_W-1:0] settleDelta;
      logic              pauseGrows;
   } expect_t;

   logic              clk;
   logic              rst;
   logic              consRun;
   logic              consCont;
   logic              consExec;
   logic              consHalt;
   logic              cpuRun;
   logic              cpuCont;
   logic              cpuExec;
   logic              cpuHalt;
   logic [STEP_W-1:0] stepCount;

   // Outputs gathered as one status word
   consStatus_t       seenFlags;
   obs_t              obsQ[$];
   integer            seed;
   logic              stimDone = 1'b0;
   int                passCount;
   int                failCount;

   assign seenFlags = '{run: cpuRun, cont: cpuCont, exec: cpuExec, halt: cpuHalt};

   consCore consCore_i
   (
      .clk       (clk),
      .rst       (rst),
      .consRun   (consRun),
      .consCont  (consCont),
      .consExec  (consExec),
      .consHalt  (consHalt),
      .cpuRun    (cpuRun),
      .cpuCont   (cpuCont),
      .cpuExec   (cpuExec),
      .cpuHalt   (cpuHalt),
      .stepCount (stepCount)
   );

   // 8 ns clock
   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic expect_t refModel(input logic [2:0] cmd);
      expect_t e;
      e = '0;
      case (cmd)
         CMD_RUN:
         begin
            // Halt drops, run held, one step per loop pass
            e.flags.run  = 1'b1;
            e.rise.run   = 1'b1;
            e.pauseGrows = 1'b1;
         end
         CMD_EXEC:
         begin
            // Single step then halted again
            e.flags.halt  = 1'b1;
            e.rise.exec   = 1'b1;
            e.checkSettle = 1'b1;
            e.settleDelta = STEP_W'(1);
         end
         CMD_CONT:
         begin
            // Run clear, so one step and back to halt
            e.flags.halt  = 1'b1;
            e.rise.cont   = 1'b1;
            e.checkSettle = 1'b1;
            e.settleDelta = STEP_W'(1);
         end
         default:
         begin
            // Reset and halt both end halted and idle
            e.flags.halt  = 1'b1;
            e.checkSettle = (cmd == CMD_RESET);
         end
      endcase
      return e;
   endfunction

   function automatic string cmdName(input logic [2:0] cmd);
      string s;
      case (cmd)
         CMD_RESET: s = "reset";
         CMD_EXEC:  s = "exec";
         CMD_CONT:  s = "cont";
         CMD_RUN:   s = "run";
         CMD_HALT:  s = "halt";
         default:   s = "unknown";
      endcase
      return s;
   endfunction

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                 input logic [31:0] gotVal);
      $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expVal, gotVal);
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Switch held for one full enable period
   task automatic pulseSwitch(input logic [2:0] cmd);
      @(posedge clk);
      case (cmd)
         CMD_RUN:  consRun  <= 1'b1;
         CMD_CONT: consCont <= 1'b1;
         CMD_EXEC: consExec <= 1'b1;
         CMD_HALT: consHalt <= 1'b1;
         default:  ;
      endcase
      repeat (CLK_DIV) @(posedge clk);
      consRun  <= 1'b0;
      consCont <= 1'b0;
      consExec <= 1'b0;
      consHalt <= 1'b0;
   endtask

   task automatic runCommand(input logic [2:0] cmd, input int testIdx);
      obs_t              o;
      logic [STEP_W-1:0] cntBefore;
      logic [STEP_W-1:0] cntSettle;
      int                pauseLen;
      o = '0;
      @(negedge clk);
      cntBefore = (cmd == CMD_RESET) ? '0 : stepCount;
      if (cmd != CMD_RESET)
         pulseSwitch(cmd);
      @(negedge clk);
      o.seen = seenFlags;
      // Halted machine first leaves halt
      if (cmd != CMD_RESET && cmd != CMD_HALT)
      begin
         while (cpuHalt)
         begin
            @(negedge clk);
            o.seen = o.seen | seenFlags;
         end
      end
      // Then comes back to halt, run excepted
      if (cmd != CMD_RUN)
      begin
         while (!cpuHalt)
         begin
            @(negedge clk);
            o.seen = o.seen | seenFlags;
         end
      end
      cntSettle = stepCount;
      o.flags   = seenFlags;
      // Random pause to watch the step counter
      pauseLen = 4 * CLK_DIV + ($random(seed) & 31);
      repeat (pauseLen) @(negedge clk);
      o.flagsAfter  = seenFlags;
      o.settleDelta = cntSettle - cntBefore;
      o.pauseDelta  = stepCount - cntSettle;
      o.testNum     = 16'(testIdx);
      o.cmd         = cmd;
      obsQ.push_back(o);
   endtask

   initial
   begin : stimulus
      logic [2:0] cmd;
      logic       running;
      int         pick;
      seed     = 32'hed9b_078b;
      rst      = 1'b1;
      consRun  = 1'b0;
      consCont = 1'b0;
      consExec = 1'b0;
      consHalt = 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      // Directed tests
      runCommand(CMD_RESET, 1);
      runCommand(CMD_EXEC, 2);
      runCommand(CMD_CONT, 3);
      runCommand(CMD_RUN, 4);
      runCommand(CMD_HALT, 5);
      // Random mix, only halt while running
      running = 1'b0;
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         if (running)
         begin
            cmd     = CMD_HALT;
            running = 1'b0;
         end
         else
         begin
            pick = ($random(seed) & 32'h7fff_ffff) % 3;
            case (pick)
               0:       cmd = CMD_EXEC;
               1:       cmd = CMD_CONT;
               default: cmd = CMD_RUN;
            endcase
            running = (cmd == CMD_RUN);
         end
         runCommand(cmd, 6 + i);
      end
      stimDone = 1'b1;
   end

   ////////////////////////////////////////
   // Compare
   ////////////////////////////////////////

   initial
   begin : compare
      obs_t    o;
      expect_t e;
      int      errs;
      passCount = 0;
      failCount = 0;
      while (!(stimDone && obsQ.size() == 0))
      begin
         @(negedge clk);
         if (obsQ.size() > 0)
         begin
            o    = obsQ.pop_front();
            e    = refModel(o.cmd);
            errs = 0;
            if (o.flags.run !== e.flags.run)
            begin
               reportMismatch("cpuRun", 32'(e.flags.run), 32'(o.flags.run));
               errs++;
            end
            if (o.flags.cont !== e.flags.cont)
            begin
               reportMismatch("cpuCont", 32'(e.flags.cont), 32'(o.flags.cont));
               errs++;
            end
            if (o.flags.exec !== e.flags.exec)
            begin
               reportMismatch("cpuExec", 32'(e.flags.exec), 32'(o.flags.exec));
               errs++;
            end
            if (o.flags.halt !== e.flags.halt)
            begin
               reportMismatch("cpuHalt", 32'(e.flags.halt), 32'(o.flags.halt));
               errs++;
            end
            // Flags must hold over the pause
            if (o.flagsAfter !== e.flags)
            begin
               reportMismatch("{cpuRun,cpuCont,cpuExec,cpuHalt}", 32'(e.flags),
                              32'(o.flagsAfter));
               errs++;
            end
            if ((o.seen & e.rise) != e.rise)
            begin
               $display("Test %0d: %s flag was never seen high", o.testNum, cmdName(o.cmd));
               errs++;
            end
            if (e.checkSettle && o.settleDelta !== e.settleDelta)
            begin
               reportMismatch("stepCount delta", 32'(e.settleDelta), 32'(o.settleDelta));
               errs++;
            end
            if (e.pauseGrows && o.pauseDelta == '0)
            begin
               $display("Test %0d: stepCount did not advance while running", o.testNum);
               errs++;
            end
            if (!e.pauseGrows && o.pauseDelta !== '0)
            begin
               reportMismatch("stepCount pause delta", 32'h0, 32'(o.pauseDelta));
               errs++;
            end
            $display("Test %0d %s: %s", o.testNum, cmdName(o.cmd), (errs == 0) ? "pass" : "FAIL");
            if (errs == 0)
               passCount++;
            else
               failCount++;
         end
      end
      $display("Tests %0d, passed %0d, failed %0d", passCount + failCount, passCount, failCount);
      if (failCount == 0 && passCount == NUM_TESTS)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Ends a run whose machine never settles
   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the machine did not settle", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== consCore.sv ====
// Console control top level joining divider, control ROM, sequencer and status block
`timescale 1ns/1ps

module consCore
   import cromPkg::*;
   import consPkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              consRun,
   input  logic              consCont,
   input  logic              consExec,
   input  logic              consHalt,
   output logic              cpuRun,
   output logic              cpuCont,
   output logic              cpuExec,
   output logic              cpuHalt,
   output logic [STEP_W-1:0] stepCount
);

   // Enable pulse shared by all registers
   logic                   clken;
   // Next micro-address into the ROM
   logic [CROM_ADDR_W-1:0] romAddr;
   // Word now in the ROM register
   cromWord_t              romWord;

   // Status flags from the console block
   consStatusIf statusIf ();

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   clkEnable clkEnable_i
   (
      .clk   (clk),
      .rst   (rst),
      .clken (clken)
   );

   cromTable cromTable_i
   (
      .clk   (clk),
      .rst   (rst),
      .clken (clken),
      .addr  (romAddr),
      .crom  (romWord)
   );

   microSeq microSeq_i
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .consHalt  (consHalt),
      .crom      (romWord),
      .status    (statusIf.sink),
      .addr      (romAddr),
      .stepCount (stepCount)
   );

   consIntf consIntf_i
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (romWord),
      .consRun  (consRun),
      .consCont (consCont),
      .consExec (consExec),
      .status   (statusIf.source)
   );

   // Status word onto the flag outputs
   assign cpuRun  = statusIf.flags.run;
   assign cpuCont = statusIf.flags.cont;
   assign cpuExec = statusIf.flags.exec;
   assign cpuHalt = statusIf.flags.halt;

endmodule

// ==== consIntf.sv ====
// Console status block setting flags from switches and clearing them from microcode
`timescale 1ns/1ps

module consIntf
   import cromPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clken,
   input  cromWord_t  crom,
   input  logic       consRun,
   input  logic       consCont,
   input  logic       consExec,
   consStatusIf.source status
);

   // Console special function selected
   logic specCons;
   // Flag registers
   logic runFlag;
   logic contFlag;
   logic execFlag;
   logic haltFlag;

   assign specCons = crom.specEn && (crom.specSel == SPEC_SEL_CONS);

   ////////////////////////////////////////
   // Flags
   ////////////////////////////////////////

   // Halt is under microcode control only
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         haltFlag <= 1'b0;
      else if (clken)
      begin
         if (specCons && crom.consFn.setHalt)
            haltFlag <= 1'b1;
         else if (specCons && crom.consFn.clrHalt)
            haltFlag <= 1'b0;
      end
   end

   // Run switch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         runFlag <= 1'b0;
      else if (clken)
      begin
         if (consRun)
            runFlag <= 1'b1;
         else if (specCons && crom.consFn.clrRun)
            runFlag <= 1'b0;
      end
   end

   // Execute switch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         execFlag <= 1'b0;
      else if (clken)
      begin
         if (consExec)
            execFlag <= 1'b1;
         else if (specCons && crom.consFn.clrExec)
            execFlag <= 1'b0;
      end
   end

   // Continue switch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         contFlag <= 1'b0;
      else if (clken)
      begin
         if (consCont)
            contFlag <= 1'b1;
         else if (specCons && crom.consFn.clrCont)
            contFlag <= 1'b0;
      end
   end

   assign status.flags = '{run: runFlag, cont: contFlag, exec: execFlag, halt: haltFlag};

   // ROM never asks to set and clear halt together
   haltExcl : assert property (@(posedge clk) disable iff (rst)
      (clken && specCons) |-> !(crom.consFn.setHalt && crom.consFn.clrHalt));

endmodule

// ==== microSeq.sv ====
// Micro-program sequencer with status dispatch, halt request latch and step counter
`timescale 1ns/1ps

module microSeq
   import cromPkg::*;
   import consPkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic                   consHalt,
   input  cromWord_t              crom,
   consStatusIf.sink              status,
   output logic [CROM_ADDR_W-1:0] addr,
   output logic [STEP_W-1:0]      stepCount
);

   // Address of the word now in the ROM register
   logic [CROM_ADDR_W-1:0] upc;
   // Latched console halt
   logic                   haltReq;

   ////////////////////////////////////////
   // Next address
   ////////////////////////////////////////

   always_comb
   begin
      addr = crom.jump;
      if (crom.dispEn)
      begin
         // Halt request wins in any state
         if (haltReq)
            addr = DISP_HALT_REQ;
         else if (status.flags.halt)
         begin
            // Halted, pick a console command
            if (status.flags.run)
               addr = DISP_RUN;
            else if (status.flags.exec)
               addr = DISP_EXEC;
            else if (status.flags.cont)
               addr = DISP_CONT;
         end
         else if (!status.flags.run)
            addr = ADDR_START;
      end
   end

   // Track the executing word
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         upc <= ADDR_START;
      else if (clken)
         upc <= addr;
   end

   ////////////////////////////////////////
   // Halt request and steps
   ////////////////////////////////////////

   // Set by switch, cleared by the halt request entry
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         haltReq <= 1'b0;
      else if (clken)
      begin
         if (consHalt)
            haltReq <= 1'b1;
         else if (upc == DISP_HALT_REQ)
            haltReq <= 1'b0;
      end
   end

   // Count stepped instructions
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         stepCount <= '0;
      else if (clken && crom.step)
         stepCount <= stepCount + 1'b1;
   end

   // Micro-address stays inside the programmed words
   addrRange : assert property (@(posedge clk) disable iff (rst)
      clken |-> (!$isunknown(addr) && addr <= ADDR_CONT_DISP));

endmodule

// ==== cromTable.sv ====
// Control ROM holding the console microprogram with a registered word output
`timescale 1ns/1ps

module cromTable
   import cromPkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic [CROM_ADDR_W-1:0] addr,
   output cromWord_t              crom
);

   // Word looked up for the incoming address
   cromWord_t romWord;

   ////////////////////////////////////////
   // Microprogram
   ////////////////////////////////////////

   always_comb
   begin
      // Default word just jumps to the start
      romWord = '0;
      case (addr)
         ADDR_START:
         begin
            // Set halt then idle
            romWord.specEn         = 1'b1;
            romWord.specSel        = SPEC_SEL_CONS;
            romWord.consFn.setHalt = 1'b1;
            romWord.jump           = DISP_HALT_LOOP;
         end
         DISP_HALT_LOOP:
         begin
            // Wait on console switches
            romWord.dispEn = 1'b1;
            romWord.jump   = DISP_HALT_LOOP;
         end
         DISP_RUN:
         begin
            romWord.specEn         = 1'b1;
            romWord.specSel        = SPEC_SEL_CONS;
            romWord.consFn.clrHalt = 1'b1;
            romWord.jump           = ADDR_RUN_LOOP;
         end
         ADDR_RUN_LOOP:
         begin
            // One step per pass, leave on halt request
            romWord.dispEn = 1'b1;
            romWord.step   = 1'b1;
            romWord.jump   = ADDR_RUN_LOOP;
         end
         DISP_HALT_REQ:
         begin
            romWord.specEn        = 1'b1;
            romWord.specSel       = SPEC_SEL_CONS;
            romWord.consFn.clrRun = 1'b1;
            romWord.jump          = ADDR_START;
         end
         DISP_EXEC:
         begin
            // Single step then back to halt
            romWord.specEn         = 1'b1;
            romWord.specSel        = SPEC_SEL_CONS;
            romWord.consFn.clrHalt = 1'b1;
            romWord.consFn.clrExec = 1'b1;
            romWord.step           = 1'b1;
            romWord.jump           = ADDR_START;
         end
         DISP_CONT:
         begin
            romWord.specEn         = 1'b1;
            romWord.specSel        = SPEC_SEL_CONS;
            romWord.consFn.clrHalt = 1'b1;
            romWord.consFn.clrCont = 1'b1;
            romWord.step           = 1'b1;
            romWord.jump           = ADDR_CONT_DISP;
         end
         ADDR_CONT_DISP:
         begin
            // Resume run loop only if run is still set
            romWord.dispEn = 1'b1;
            romWord.jump   = ADDR_RUN_LOOP;
         end
         default:
         begin
            romWord.jump = ADDR_START;
         end
      endcase
   end

   // Registered ROM output, reset to a plain jump to the start
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         crom <= '0;
      else if (clken)
         crom <= romWord;
   end

endmodule

// ==== clkEnable.sv ====
// Clock enable divider giving one enable pulse per divide period
`timescale 1ns/1ps

module clkEnable
   import consPkg::*;
(
   input  logic clk,
   input  logic rst,
   output logic clken
);

   // Divide counter
   logic [DIV_W-1:0] divCnt;
   logic             divTerm;

   // Terminal count
   assign divTerm = (divCnt == DIV_W'(CLK_DIV - 1));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         divCnt <= '0;
      else if (divTerm)
         divCnt <= '0;
      else
         divCnt <= divCnt + 1'b1;
   end

   // One pulse per period
   assign clken = divTerm;

   // Enable stays a single cycle wide
   pulseWidth : assert property (@(posedge clk) disable iff (rst) clken |=> !clken);

endmodule

// ==== consStatusIf.sv ====
// Console status interface carrying the run, continue, execute and halt flags
`timescale 1ns/1ps

interface consStatusIf
   import consPkg::*;
();

   // Flags as one packed word
   consStatus_t flags;

   // Console block drives the flags
   modport source
   (
      output flags
   );

   // Sequencer and top level only look
   modport sink
   (
      input flags
   );

endinterface

// ==== consPkg.sv ====
// Console package with status flag layout, enable divide ratio and step counter width
package consPkg;

   ////////////////////////////////////////
   // Timing
   ////////////////////////////////////////

   // Clock cycles per enable pulse
   localparam int CLK_DIV = 4;
   localparam int DIV_W   = $clog2(CLK_DIV);

   ////////////////////////////////////////
   // Status
   ////////////////////////////////////////

   // Instruction step counter width
   localparam int STEP_W = 16;

   // Console status flags
   typedef struct packed {
      logic run;
      logic cont;
      logic exec;
      logic halt;
   } consStatus_t;

endpackage

// ==== cromPkg.sv ====
// Control ROM package with microword layout, select codes and program entry addresses
package cromPkg;

   ////////////////////////////////////////
   // ROM geometry
   ////////////////////////////////////////

   localparam int CROM_DEPTH  = 16;
   localparam int CROM_ADDR_W = 4;

   // Special function select codes
   localparam logic [1:0] SPEC_SEL_CONS = 2'd1;

   ////////////////////////////////////////
   // Program entry points
   ////////////////////////////////////////

   // Restart word which sets halt
   localparam logic [CROM_ADDR_W-1:0] ADDR_START     = 4'd0;
   localparam logic [CROM_ADDR_W-1:0] DISP_HALT_LOOP = 4'd1;
   localparam logic [CROM_ADDR_W-1:0] DISP_RUN       = 4'd2;
   localparam logic [CROM_ADDR_W-1:0] ADDR_RUN_LOOP  = 4'd3;
   localparam logic [CROM_ADDR_W-1:0] DISP_HALT_REQ  = 4'd4;
   localparam logic [CROM_ADDR_W-1:0] DISP_EXEC      = 4'd5;
   localparam logic [CROM_ADDR_W-1:0] DISP_CONT      = 4'd6;
   // Second half of the continue sequence
   localparam logic [CROM_ADDR_W-1:0] ADDR_CONT_DISP = 4'd7;

   // Console function bits
   typedef struct packed {
      logic setHalt;
      logic clrHalt;
      logic clrRun;
      logic clrExec;
      logic clrCont;
   } consFn_t;

   // Microword, 16 bits in all
   typedef struct packed {
      logic [CROM_ADDR_W-1:0] jump;
      logic                   dispEn;
      logic                   specEn;
      logic [1:0]             specSel;
      consFn_t                consFn;
      logic                   step;
      logic [1:0]             spare;
   } cromWord_t;

endpackage
